// ==== Bender.yml ====
package:
  name: parser

sources:
  - rtl/parser_pkg.sv
  - rtl/action_table.sv
  - rtl/header_capture.sv
  - rtl/field_extractor.sv
  - rtl/phv_assembler.sv
  - rtl/parser_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_parser.sv

// ==== parser.f ====
+incdir+include
rtl/parser_pkg.sv
rtl/action_table.sv
rtl/header_capture.sv
rtl/field_extractor.sv
rtl/phv_assembler.sv
rtl/parser_top.sv
sim/tb_parser.sv

// ==== rtl/action_table.sv ====
`default_nettype none

module action_table
    import parser_pkg::*;
#(
    parameter int TABLE_DEPTH = 16
) (
    input  wire                            axis_clk,
    input  wire                            aresetn,
    input  wire                            wr_valid_i,
    input  table_wr_t                      wr_i,
    input  wire [$clog2(TABLE_DEPTH)-1:0]  rd_index_i,
    output table_entry_t                   rd_entry_o
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    table_entry_t entries [TABLE_DEPTH];
    logic [IDX_W-1:0] wr_index;

    // only the low bits address the table
    assign wr_index = wr_i.index[IDX_W-1:0];

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_valid_i) begin
            entries[wr_index] <= wr_i.entry;
        end
    end

    // same-cycle write is not seen by this read
    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            rd_entry_o <= '0;
        end else begin
            rd_entry_o <= entries[rd_index_i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/field_extractor.sv ====
`default_nettype none

module field_extractor
    import parser_pkg::*;
(
    input  wire           axis_clk,
    input  wire           aresetn,
    input  wire           valid_i,
    input  hdr_t          hdr_i,
    input  parse_action_t action_i,
    output logic          valid_o,
    output field_result_t result_o
);

    logic [2:0]                   num_bytes;
    logic [OFFSET_W:0]            pos;
    logic [7:0]                   cur_byte;
    logic [MAX_FIELD_BYTES*8-1:0] value;

    // bytes shift in from the right, first byte ends up most significant
    always_comb begin
        case (action_i.kind)
            KIND_2B: num_bytes = 3'd2;
            KIND_4B: num_bytes = 3'd4;
            KIND_6B: num_bytes = 3'd6;
            default: num_bytes = 3'd0;
        endcase
        value    = '0;
        pos      = '0;
        cur_byte = '0;
        for (int b = 0; b < MAX_FIELD_BYTES; b++) begin
            pos = {1'b0, action_i.offset} + (OFFSET_W+1)'(b);
            // past the window reads as zero
            cur_byte = (pos < HDR_BYTES) ? hdr_i[pos[OFFSET_W-1:0]] : 8'h00;
            if (b < num_bytes) begin
                value = {value[(MAX_FIELD_BYTES-1)*8-1:0], cur_byte};
            end
        end
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (valid_i) begin
            result_o.kind  <= action_i.kind;
            result_o.index <= action_i.index;
            result_o.value <= value;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/header_capture.sv ====
`default_nettype none

module header_capture
    import parser_pkg::*;
#(
    parameter int TABLE_DEPTH = 16
) (
    input  wire                            axis_clk,
    input  wire                            aresetn,
    input  wire                            hdr_valid_i,
    input  hdr_t                           hdr_i,
    output logic [$clog2(TABLE_DEPTH)-1:0] rd_index_o,
    input  table_entry_t                   rd_entry_i,
    output logic                           ext_valid_o,
    output hdr_t                           ext_hdr_o,
    output parse_action_t                  ext_action_o [NUM_EXTRACTORS],
    output vlan_id_t                       vlan_id_o
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    logic     cap_valid;
    hdr_t     cap_hdr;
    vlan_id_t cap_vlan;
    vlan_id_t ext_vlan;

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            cap_valid   <= 1'b0;
            ext_valid_o <= 1'b0;
        end else begin
            cap_valid   <= hdr_valid_i;
            ext_valid_o <= cap_valid;
        end
    end

    // 802.1Q TCI, VID is the low 12 bits
    always_ff @(posedge axis_clk) begin
        if (hdr_valid_i) begin
            cap_hdr  <= hdr_i;
            cap_vlan <= {hdr_i[VLAN_BYTE][3:0], hdr_i[VLAN_BYTE+1]};
        end
        ext_hdr_o <= cap_hdr;
        ext_vlan  <= cap_vlan;
        // extra stage so the vlan meets the extractor results
        vlan_id_o <= ext_vlan;
    end

    assign rd_index_o = cap_vlan[IDX_W-1:0];

    always_comb begin
        for (int i = 0; i < NUM_EXTRACTORS; i++) begin
            ext_action_o[i] = rd_entry_i[i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/parser_pkg.sv ====
`default_nettype none

package parser_pkg;

    localparam int HDR_BYTES       = 64;
    localparam int NUM_EXTRACTORS  = 6;
    localparam int NUM_CONTAINERS  = 4;
    localparam int VLAN_BYTE       = 14;
    localparam int CONT_IDX_W      = 2;
    localparam int OFFSET_W        = 6;
    localparam int TBL_INDEX_W     = 4;
    localparam int MAX_FIELD_BYTES = 6;

    // byte 0 is the first byte on the wire, in the MSB position
    typedef logic [0:HDR_BYTES-1][7:0] hdr_t;

    typedef logic [11:0] vlan_id_t;

    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_2B   = 2'd1,
        KIND_4B   = 2'd2,
        KIND_6B   = 2'd3
    } container_kind_e;

    typedef struct packed {
        container_kind_e       kind;
        logic [CONT_IDX_W-1:0] index;
        logic [OFFSET_W-1:0]   offset;
    } parse_action_t;

    // action i sits at entry index i
    typedef parse_action_t [NUM_EXTRACTORS-1:0] table_entry_t;

    typedef struct packed {
        logic [TBL_INDEX_W-1:0] index;
        table_entry_t           entry;
    } table_wr_t;

    typedef struct packed {
        container_kind_e              kind;
        logic [CONT_IDX_W-1:0]        index;
        logic [MAX_FIELD_BYTES*8-1:0] value;
    } field_result_t;

    typedef struct packed {
        logic [NUM_CONTAINERS-1:0][47:0] cont_6b;
        logic [NUM_CONTAINERS-1:0][31:0] cont_4b;
        logic [NUM_CONTAINERS-1:0][15:0] cont_2b;
        vlan_id_t                        vlan_id;
    } phv_t;

endpackage

`default_nettype wire

// ==== rtl/parser_top.sv ====
`default_nettype none

module parser_top
    import parser_pkg::*;
#(
    parameter int TABLE_DEPTH = 16
) (
    input  wire       axis_clk,
    input  wire       aresetn,
    input  wire       hdr_valid_i,
    input  hdr_t      hdr_i,
    input  wire       tbl_wr_valid_i,
    input  table_wr_t tbl_wr_i,
    output logic      phv_valid_o,
    output phv_t      phv_o
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    logic [IDX_W-1:0] rd_index;
    table_entry_t     rd_entry;
    logic             ext_valid;
    hdr_t             ext_hdr;
    parse_action_t    ext_action [NUM_EXTRACTORS];
    vlan_id_t         vlan_id;
    logic             res_valid  [NUM_EXTRACTORS];
    field_result_t    res        [NUM_EXTRACTORS];

    header_capture #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_capture (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .hdr_valid_i  (hdr_valid_i),
        .hdr_i        (hdr_i),
        .rd_index_o   (rd_index),
        .rd_entry_i   (rd_entry),
        .ext_valid_o  (ext_valid),
        .ext_hdr_o    (ext_hdr),
        .ext_action_o (ext_action),
        .vlan_id_o    (vlan_id)
    );

    action_table #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_table (
        .axis_clk   (axis_clk),
        .aresetn    (aresetn),
        .wr_valid_i (tbl_wr_valid_i),
        .wr_i       (tbl_wr_i),
        .rd_index_i (rd_index),
        .rd_entry_o (rd_entry)
    );

    // one extractor per action slot
    for (genvar g = 0; g < NUM_EXTRACTORS; g++) begin : g_ext
        field_extractor u_ext (
            .axis_clk (axis_clk),
            .aresetn  (aresetn),
            .valid_i  (ext_valid),
            .hdr_i    (ext_hdr),
            .action_i (ext_action[g]),
            .valid_o  (res_valid[g]),
            .result_o (res[g])
        );
    end

    phv_assembler u_assembler (
        .axis_clk    (axis_clk),
        .aresetn     (aresetn),
        .valid_i     (res_valid),
        .result_i    (res),
        .vlan_id_i   (vlan_id),
        .phv_valid_o (phv_valid_o),
        .phv_o       (phv_o)
    );

endmodule

`default_nettype wire

// ==== rtl/phv_assembler.sv ====
`default_nettype none

module phv_assembler
    import parser_pkg::*;
(
    input  wire           axis_clk,
    input  wire           aresetn,
    input  wire           valid_i  [NUM_EXTRACTORS],
    input  field_result_t result_i [NUM_EXTRACTORS],
    input  vlan_id_t      vlan_id_i,
    output logic          phv_valid_o,
    output phv_t          phv_o
);

    phv_t phv_next;

    // fresh PHV per packet, later extractors win on a shared container
    always_comb begin
        phv_next = '0;
        for (int i = 0; i < NUM_EXTRACTORS; i++) begin
            if (valid_i[i]) begin
                case (result_i[i].kind)
                    KIND_2B: begin
                        phv_next.cont_2b[result_i[i].index] = result_i[i].value[15:0];
                    end
                    KIND_4B: begin
                        phv_next.cont_4b[result_i[i].index] = result_i[i].value[31:0];
                    end
                    KIND_6B: begin
                        phv_next.cont_6b[result_i[i].index] = result_i[i].value[47:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
        phv_next.vlan_id = vlan_id_i;
    end

    // all extractor valids move together, extractor 0 drives the strobe
    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            phv_valid_o <= 1'b0;
            phv_o       <= '0;
        end else begin
            phv_valid_o <= valid_i[0];
            if (valid_i[0]) begin
                phv_o <= phv_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== include/parser_tb_util.svh ====
`ifndef PARSER_TB_UTIL_SVH
`define PARSER_TB_UTIL_SVH

// x^32 + x^22 + x^2 + x + 1, shifting right
function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

// one lfsr step per bit taken
function automatic logic [63:0] random_bits(input int nbits);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
        lfsr_state = galois_step(lfsr_state);
        v = {v[62:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic parse_action_t make_action(input container_kind_e kind,
                                              input logic [1:0] index,
                                              input logic [5:0] offset);
    parse_action_t a;
    a.kind   = kind;
    a.index  = index;
    a.offset = offset;
    return a;
endfunction

// expected PHV for one header under one table entry
function automatic phv_t expected_phv(input hdr_t h, input table_entry_t e);
    phv_t          p;
    parse_action_t a;
    logic [47:0]   field;
    int            nbytes;
    int            pos;
    p = '0;
    for (int i = 0; i < NUM_EXTRACTORS; i++) begin
        a = e[i];
        field = '0;
        case (a.kind)
            KIND_2B: nbytes = 2;
            KIND_4B: nbytes = 4;
            KIND_6B: nbytes = 6;
            default: nbytes = 0;
        endcase
        for (int j = 0; j < nbytes; j++) begin
            pos = int'(a.offset) + j;
            field = field << 8;
            // bytes past the window stay zero
            if (pos < HDR_BYTES) begin
                field[7:0] = h[pos];
            end
        end
        case (a.kind)
            KIND_2B: p.cont_2b[a.index] = field[15:0];
            KIND_4B: p.cont_4b[a.index] = field[31:0];
            KIND_6B: p.cont_6b[a.index] = field[47:0];
            default: ;
        endcase
    end
    p.vlan_id = {h[14][3:0], h[15]};
    return p;
endfunction

task automatic check_vlan(input vlan_id_t got, input vlan_id_t want);
    if (got !== want) begin
        abort_run($sformatf("mismatch at %0t: vlan_id got %h expected %h",
                            $time, got, want));
    end
endtask

task automatic check_phv(input phv_t got, input phv_t want);
    for (int c = 0; c < NUM_CONTAINERS; c++) begin
        if (got.cont_6b[c] !== want.cont_6b[c]) begin
            abort_run($sformatf("mismatch at %0t: cont_6b[%0d] got %h expected %h",
                                $time, c, got.cont_6b[c], want.cont_6b[c]));
        end
        if (got.cont_4b[c] !== want.cont_4b[c]) begin
            abort_run($sformatf("mismatch at %0t: cont_4b[%0d] got %h expected %h",
                                $time, c, got.cont_4b[c], want.cont_4b[c]));
        end
        if (got.cont_2b[c] !== want.cont_2b[c]) begin
            abort_run($sformatf("mismatch at %0t: cont_2b[%0d] got %h expected %h",
                                $time, c, got.cont_2b[c], want.cont_2b[c]));
        end
    end
endtask

`endif

// ==== sim/tb_parser.sv ====
`default_nettype none

module tb_parser
    import parser_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 100;
    localparam int TABLE_DEPTH = 16;
    // headers sent by tests 1 to 5
    localparam int NUM_HEADERS = 2 + 32 + 3 + 8 + 2;

    logic      axis_clk = 1'b0;
    logic      aresetn;
    logic      hdr_valid_i;
    hdr_t      hdr_i;
    logic      tbl_wr_valid_i;
    table_wr_t tbl_wr_i;
    logic      phv_valid_o;
    phv_t      phv_o;

    logic [31:0]  lfsr_state = 32'hd89b82a1;
    table_entry_t tbl_copy [TABLE_DEPTH];
    phv_t         exp_q [$];
    logic [3:0]   strobe_hist = '0;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    `include "parser_tb_util.svh"

    parser_top #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) DUT (
        .axis_clk       (axis_clk),
        .aresetn        (aresetn),
        .hdr_valid_i    (hdr_valid_i),
        .hdr_i          (hdr_i),
        .tbl_wr_valid_i (tbl_wr_valid_i),
        .tbl_wr_i       (tbl_wr_i),
        .phv_valid_o    (phv_valid_o),
        .phv_o          (phv_o)
    );

    always #(CLK_PERIOD/2) axis_clk = ~axis_clk;

    function automatic hdr_t random_header(input logic [3:0] vlan_low);
        logic [511:0] bits;
        hdr_t         h;
        bits = '0;
        for (int w = 0; w < 8; w++) begin
            bits = {bits[447:0], random_bits(64)};
        end
        h = hdr_t'(bits);
        h[15][3:0] = vlan_low;
        return h;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge axis_clk);
            #5;
            hdr_valid_i    = 1'b0;
            tbl_wr_valid_i = 1'b0;
        end
    endtask

    task automatic write_entry(input logic [3:0] idx, input table_entry_t e);
        @(posedge axis_clk);
        #5;
        hdr_valid_i    = 1'b0;
        tbl_wr_valid_i = 1'b1;
        tbl_wr_i.index = idx;
        tbl_wr_i.entry = e;
        tbl_copy[idx]  = e;
    endtask

    // expected PHV uses the table as the DUT will read it one edge later
    task automatic send_header(input hdr_t h);
        logic [3:0] idx;
        idx = h[15][3:0];
        @(posedge axis_clk);
        #5;
        tbl_wr_valid_i = 1'b0;
        hdr_valid_i    = 1'b1;
        hdr_i          = h;
        exp_q.push_back(expected_phv(h, tbl_copy[idx]));
    endtask

    always @(posedge axis_clk) begin
        strobe_hist <= {strobe_hist[2:0], hdr_valid_i};
    end

    // outputs are sampled mid-cycle
    always @(negedge axis_clk) begin : compare_phv
        phv_t want;
        if (phv_valid_o !== strobe_hist[3]) begin
            abort_run($sformatf("mismatch at %0t: phv_valid_o got %b expected %b",
                                $time, phv_valid_o, strobe_hist[3]));
        end else if (phv_valid_o) begin
            if (exp_q.size() == 0) begin
                abort_run("PHV strobe arrived with no header outstanding");
            end else begin
                want = exp_q.pop_front();
                check_vlan(phv_o.vlan_id, want.vlan_id);
                check_phv(phv_o, want);
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (10 * NUM_HEADERS + 100));
        abort_run($sformatf("timeout: run still busy after %0d cycles",
                            10 * NUM_HEADERS + 100));
    end

    initial begin
        table_entry_t e;
        hdr_t         h1;
        hdr_t         h2;
        aresetn        = 1'b0;
        hdr_valid_i    = 1'b0;
        hdr_i          = '0;
        tbl_wr_valid_i = 1'b0;
        tbl_wr_i       = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            tbl_copy[i] = '0;
        end
        repeat (2) @(posedge axis_clk);
        #5;
        aresetn = 1'b1;

        // empty table gives only the vlan
        idle(4);
        send_header(random_header(4'h3));
        send_header(random_header(4'hc));
        idle(4);

        // random entries on every index
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            write_entry(4'(i), table_entry_t'(random_bits(60)));
        end
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                send_header(random_header(4'(i)));
            end
        end
        idle(4);

        // window edge and overlapping containers
        e[0] = make_action(KIND_6B, 2'd0, 6'd59);
        e[1] = make_action(KIND_4B, 2'd1, 6'd61);
        e[2] = make_action(KIND_6B, 2'd1, 6'd63);
        e[3] = make_action(KIND_2B, 2'd3, 6'd63);
        e[4] = make_action(KIND_2B, 2'd3, 6'd20);
        e[5] = make_action(KIND_4B, 2'd0, 6'd62);
        write_entry(4'd5, e);
        repeat (3) begin
            send_header(random_header(4'd5));
        end
        idle(4);

        // back to back
        repeat (8) begin
            send_header(random_header(4'(random_bits(4))));
        end
        idle(4);

        // rewrite between two headers of one vlan
        h1 = random_header(4'd9);
        h2 = random_header(4'd9);
        h2[14] = h1[14];
        h2[15] = h1[15];
        write_entry(4'd9, table_entry_t'(random_bits(60)));
        send_header(h1);
        write_entry(4'd9, table_entry_t'(random_bits(60)));
        send_header(h2);
        idle(1);

        while (exp_q.size() != 0) begin
            @(posedge axis_clk);
        end
        idle(4);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
